//--- Makefile
TOP := front_end_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths with a meaning.
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] addr_t;  // Byte address.
    typedef logic [31:0] instr_t; // One instruction word.
    typedef logic [2:0] count_t;  // Queue occupancy, 0 to queue_depth.

    localparam addr_t reset_vector = 32'h0000_0000;
    localparam addr_t pair_step = 32'd8; // Two words per fetch.
    localparam int queue_depth = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Structs passed between stages.
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic valid;
        addr_t target;
    } redirect_t;

    typedef struct packed {
        addr_t pc0;
        addr_t pc1;
        instr_t instr0;
        instr_t instr1;
    } fetch_pair_t;

    // Redirect sources, highest priority first.
    typedef struct packed {
        logic trap;
        logic mret;
        logic miss;
        addr_t mtvec;
        addr_t mepc;
        addr_t miss_addr;
    } trap_in_t;

    typedef enum logic [1:0] {
        idle,
        busy,
        drain
    } fetch_state_t;

endpackage

`default_nettype wire

//--- logic/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    push,
    input  fetch_pkg::fetch_pair_t  push_pair,
    input  logic                    flush,
    input  logic                    out_ready,
    output fetch_pkg::count_t       count,
    output logic                    out_valid,
    output fetch_pkg::fetch_pair_t  out_pair
);

    fetch_pkg::fetch_pair_t slots [fetch_pkg::queue_depth];

    logic [$clog2(fetch_pkg::queue_depth)-1:0] rd_ptr;
    logic [$clog2(fetch_pkg::queue_depth)-1:0] wr_ptr;
    fetch_pkg::count_t                         used;

    logic do_push;
    logic do_pop;
    logic full;

    assign full = (used == fetch_pkg::count_t'(fetch_pkg::queue_depth));
    assign out_valid = (used != '0);
    assign out_pair = slots[rd_ptr];
    assign count = used;

    assign do_pop = out_valid & out_ready;
    assign do_push = push & (!full | do_pop); // Full slot frees as the head leaves.

    always_ff @(posedge clock) begin
        if (!reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            used <= '0;
        end else if (flush) begin
            rd_ptr <= '0; // Flush wins over a push.
            wr_ptr <= '0;
            used <= '0;
        end else begin
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            used <= used + fetch_pkg::count_t'(do_push) - fetch_pkg::count_t'(do_pop);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pair storage.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (do_push && !flush) begin
            slots[wr_ptr] <= push_pair;
        end
    end

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                    clock,
    input  logic                    reset,
    input  fetch_pkg::redirect_t    redirect,
    input  mem_pkg::imem_rsp_t      imem0_rsp,
    input  mem_pkg::imem_rsp_t      imem1_rsp,
    input  fetch_pkg::count_t       count,
    output mem_pkg::imem_req_t      imem0_req,
    output mem_pkg::imem_req_t      imem1_req,
    output logic                    push,
    output fetch_pkg::fetch_pair_t  push_pair,
    output logic                    flush
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t state_next;

    fetch_pkg::addr_t  pc;      // Next fetch address.
    fetch_pkg::addr_t  pair_pc; // Address of the pair in flight.
    logic              owed;    // Request outstanding on both banks.
    logic              got0;
    logic              got1;
    fetch_pkg::instr_t data0;
    fetch_pkg::instr_t data1;

    logic              arrive0;
    logic              arrive1;
    logic              joined;
    logic              issue;
    fetch_pkg::instr_t word0;
    fetch_pkg::instr_t word1;

    ////////////////////////////////////////////////////////////////////////////
    // Join of the two bank answers.
    ////////////////////////////////////////////////////////////////////////////

    assign arrive0 = got0 | imem0_rsp.mem_ready;
    assign arrive1 = got1 | imem1_rsp.mem_ready;
    assign joined = owed & arrive0 & arrive1;

    assign word0 = got0 ? data0 : imem0_rsp.mem_rdata;
    assign word1 = got1 ? data1 : imem1_rsp.mem_rdata;

    // Room is counted with the pair being pushed now.
    assign issue = (state == fetch_pkg::busy) && !redirect.valid && (!owed || joined)
                   && (int'(count) + int'(joined) < fetch_pkg::queue_depth);

    always_comb begin
        state_next = state;
        case (state)
            fetch_pkg::idle: begin
                state_next = fetch_pkg::busy;
            end
            fetch_pkg::busy: begin
                if (redirect.valid && owed && !joined) begin
                    state_next = fetch_pkg::drain; // Old answers still owed.
                end
            end
            fetch_pkg::drain: begin
                if (joined) begin
                    state_next = fetch_pkg::busy;
                end
            end
            default: begin
                state_next = fetch_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= fetch_pkg::idle;
            pc <= fetch_pkg::reset_vector;
            owed <= 1'b0;
            got0 <= 1'b0;
            got1 <= 1'b0;
        end else begin
            state <= state_next;
            if (redirect.valid) begin
                pc <= redirect.target;
            end else if (issue) begin
                pc <= pc + fetch_pkg::pair_step;
            end
            if (issue) begin
                owed <= 1'b1;
            end else if (joined) begin
                owed <= 1'b0;
            end
            got0 <= owed & arrive0 & !joined;
            got1 <= owed & arrive1 & !joined;
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            pair_pc <= pc;
        end
        if (imem0_rsp.mem_ready) begin
            data0 <= imem0_rsp.mem_rdata;
        end
        if (imem1_rsp.mem_ready) begin
            data1 <= imem1_rsp.mem_rdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs.
    ////////////////////////////////////////////////////////////////////////////

    assign imem0_req = '{mem_valid: issue, mem_addr: pc};
    assign imem1_req = '{mem_valid: issue, mem_addr: pc + 32'd4};

    // A join in drain belongs to the old stream and is dropped.
    assign push = (state == fetch_pkg::busy) && joined && !redirect.valid;
    assign push_pair = '{pc0: pair_pc, pc1: pair_pc + 32'd4, instr0: word0, instr1: word1};
    assign flush = redirect.valid;

endmodule

`default_nettype wire

//--- logic/front_end.sv
`timescale 1ns/1ps
`default_nettype none

module front_end (
    input  logic                    clock,
    input  logic                    reset,
    input  fetch_pkg::trap_in_t     trap_in,
    input  mem_pkg::imem_rsp_t      imem0_rsp,
    input  mem_pkg::imem_rsp_t      imem1_rsp,
    input  logic                    out_ready,
    output mem_pkg::imem_req_t      imem0_req,
    output mem_pkg::imem_req_t      imem1_req,
    output logic                    out_valid,
    output fetch_pkg::fetch_pair_t  out_pair
);

    fetch_pkg::redirect_t   redirect;
    fetch_pkg::fetch_pair_t push_pair;
    fetch_pkg::count_t      count;
    logic                   push;
    logic                   flush;

    redirect_arbiter u_redirect_arbiter (
        .clock    (clock),
        .reset    (reset),
        .trap_in  (trap_in),
        .redirect (redirect)
    );

    fetch_stage u_fetch_stage (
        .clock     (clock),
        .reset     (reset),
        .redirect  (redirect),
        .imem0_rsp (imem0_rsp),
        .imem1_rsp (imem1_rsp),
        .count     (count),
        .imem0_req (imem0_req),
        .imem1_req (imem1_req),
        .push      (push),
        .push_pair (push_pair),
        .flush     (flush)
    );

    fetch_queue u_fetch_queue (
        .clock     (clock),
        .reset     (reset),
        .push      (push),
        .push_pair (push_pair),
        .flush     (flush),
        .out_ready (out_ready),
        .count     (count),
        .out_valid (out_valid),
        .out_pair  (out_pair)
    );

endmodule

`default_nettype wire

//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Valid is a single pulse carrying the address.
    typedef struct packed {
        logic mem_valid;
        fetch_pkg::addr_t mem_addr;
    } imem_req_t;

    // Ready pulses once per request, with the data.
    typedef struct packed {
        logic mem_ready;
        fetch_pkg::instr_t mem_rdata;
    } imem_rsp_t;

endpackage

`default_nettype wire

//--- logic/redirect_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module redirect_arbiter (
    input  logic                  clock,
    input  logic                  reset,
    input  fetch_pkg::trap_in_t   trap_in,
    output fetch_pkg::redirect_t  redirect
);

    fetch_pkg::addr_t sel_target;
    fetch_pkg::addr_t target_q;
    logic             any_source;
    logic             valid_q;

    assign any_source = trap_in.trap | trap_in.mret | trap_in.miss;

    // Trap over mret over miss.
    always_comb begin
        if (trap_in.trap) begin
            sel_target = trap_in.mtvec;
        end else if (trap_in.mret) begin
            sel_target = trap_in.mepc;
        end else begin
            sel_target = trap_in.miss_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= any_source;
        end
    end

    always_ff @(posedge clock) begin
        target_q <= sel_target;
    end

    assign redirect = '{valid: valid_q, target: target_q};

endmodule

`default_nettype wire

//--- tb.f
logic/fetch_pkg.sv
logic/mem_pkg.sv
logic/redirect_arbiter.sv
logic/fetch_stage.sv
logic/fetch_queue.sv
logic/front_end.sv
verif/tb_clock.sv
verif/imem_model.sv
verif/front_end_tb.sv

//--- verif/front_end_tb.sv
`timescale 1ns/1ps
`default_nettype none

module front_end_tb;

    localparam int planned_transfers = 400;
    localparam int warmup_transfers = 20; // Straight-line run before any redirect.
    localparam int cycle_ns = 100;
    localparam logic [31:0] data_mask = 32'ha5a5a5a5;

    logic                   clock;
    logic                   reset;
    logic                   out_ready;
    logic                   out_valid;
    fetch_pkg::trap_in_t    trap_in;
    fetch_pkg::fetch_pair_t out_pair;
    mem_pkg::imem_req_t     imem0_req;
    mem_pkg::imem_req_t     imem1_req;
    mem_pkg::imem_rsp_t     imem0_rsp;
    mem_pkg::imem_rsp_t     imem1_rsp;

    logic [31:0]      rng_state = 32'h3db1adbf;
    int               error_count = 0;
    int               protocol_errors;
    int               transfers = 0;
    int               stale_left;   // Transfers still from the old stream.
    logic             await_target;
    fetch_pkg::addr_t expected_pc;

    tb_clock u_clock (
        .clock (clock)
    );

    imem_model u_imem (
        .clock           (clock),
        .reset           (reset),
        .imem0_req       (imem0_req),
        .imem1_req       (imem1_req),
        .imem0_rsp       (imem0_rsp),
        .imem1_rsp       (imem1_rsp),
        .protocol_errors (protocol_errors)
    );

    front_end DUT (
        .clock     (clock),
        .reset     (reset),
        .trap_in   (trap_in),
        .imem0_rsp (imem0_rsp),
        .imem1_rsp (imem1_rsp),
        .out_ready (out_ready),
        .imem0_req (imem0_req),
        .imem1_req (imem1_req),
        .out_valid (out_valid),
        .out_pair  (out_pair)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers.
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        assert (got === expected) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    // One or more sources at once, pair-aligned targets.
    function automatic fetch_pkg::trap_in_t random_redirect();
        logic [2:0]          sources;
        fetch_pkg::trap_in_t t;
        sources = 3'((next_random() % 7) + 1);
        t.trap = sources[2];
        t.mret = sources[1];
        t.miss = sources[0];
        t.mtvec = next_random() & 32'h0000_fff8;
        t.mepc = next_random() & 32'h0000_fff8;
        t.miss_addr = next_random() & 32'h0000_fff8;
        return t;
    endfunction

    function automatic fetch_pkg::addr_t redirect_target(input fetch_pkg::trap_in_t t);
        if (t.trap) begin
            return t.mtvec;
        end else if (t.mret) begin
            return t.mepc;
        end
        return t.miss_addr;
    endfunction

    task automatic check_quiet();
        compare_word("out_valid", 32'(out_valid), 32'd0);
        compare_word("imem0_req.mem_valid", 32'(imem0_req.mem_valid), 32'd0);
        compare_word("imem1_req.mem_valid", 32'(imem1_req.mem_valid), 32'd0);
    endtask

    task automatic check_pair();
        if (await_target) begin
            compare_word("out_pair.pc0 after redirect", out_pair.pc0, expected_pc);
        end else begin
            compare_word("out_pair.pc0", out_pair.pc0, expected_pc);
        end
        compare_word("out_pair.pc1", out_pair.pc1, expected_pc + 32'd4);
        compare_word("out_pair.instr0", out_pair.instr0, expected_pc ^ data_mask);
        compare_word("out_pair.instr1", out_pair.instr1, (expected_pc + 32'd4) ^ data_mask);
        expected_pc = expected_pc + fetch_pkg::pair_step;
        await_target = 1'b0;
    endtask

    task automatic print_summary();
        $display("Summary: %0d transfers, %0d check errors, %0d protocol errors",
                 transfers, error_count, protocol_errors);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and reference pc model.
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        reset = 1'b0;
        out_ready = 1'b0;
        trap_in = '0;
        expected_pc = fetch_pkg::reset_vector;
        stale_left = 0;
        await_target = 1'b0;
        repeat (5) begin
            @(negedge clock);
            check_quiet();
        end
        reset = 1'b1;
        while (transfers < planned_transfers) begin
            @(negedge clock);
            r = next_random();
            out_ready = (r % 10) < 2; // Drains slower than fetch, so the queue fills.
            if (transfers >= warmup_transfers && (next_random() % 25) == 0) begin
                trap_in = random_redirect();
                expected_pc = redirect_target(trap_in);
                await_target = 1'b1;
                stale_left = 2; // This edge and the flush edge.
            end else begin
                trap_in = '0;
            end
            // Outputs are stable since the last rising edge.
            if (out_valid && out_ready && stale_left == 0) begin
                check_pair();
                transfers++;
            end
            if (stale_left > 0) begin
                stale_left--;
            end
        end
        print_summary();
        if (error_count == 0 && protocol_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(planned_transfers * 20 * cycle_ns);
        $display("ERROR: watchdog expired after %0d of %0d transfers",
                 transfers, planned_transfers);
        print_summary();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/imem_model.sv
`timescale 1ns/1ps
`default_nettype none

module imem_model (
    input  logic               clock,
    input  logic               reset,
    input  mem_pkg::imem_req_t imem0_req,
    input  mem_pkg::imem_req_t imem1_req,
    output mem_pkg::imem_rsp_t imem0_rsp,
    output mem_pkg::imem_rsp_t imem1_rsp,
    output int                 protocol_errors
);

    localparam logic [31:0] data_mask = 32'ha5a5a5a5;

    mem_pkg::imem_req_t req [2];
    mem_pkg::imem_rsp_t rsp [2];
    logic               pending [2]; // Bank still owes an answer.
    int                 left [2];
    fetch_pkg::addr_t   addr [2];
    logic [31:0]        rng = 32'h3db1adbf;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign req[0] = imem0_req;
    assign req[1] = imem1_req;
    assign imem0_rsp = rsp[0];
    assign imem1_rsp = rsp[1];

    always @(posedge clock) begin
        if (!reset) begin
            protocol_errors = 0;
        end
        for (int b = 0; b < 2; b++) begin
            rsp[b] <= '0;
            if (!reset) begin
                pending[b] = 1'b0;
            end else begin
                if (req[b].mem_valid) begin
                    assert (!pending[b]) else begin
                        $display("ERROR: bank %0d got a request while an answer is still owed", b);
                        protocol_errors++;
                    end
                    rng = xorshift(rng);
                    pending[b] = 1'b1;
                    addr[b] = req[b].mem_addr;
                    left[b] = int'(rng % 4) + 1; // 1 to 4 cycles.
                end
                if (pending[b]) begin
                    left[b] = left[b] - 1;
                    if (left[b] == 0) begin
                        pending[b] = 1'b0;
                        rsp[b] <= '{mem_ready: 1'b1, mem_rdata: addr[b] ^ data_mask};
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clock
);

    localparam int half_period_ns = 50; // 100 ns period.

    initial begin
        clock = 1'b0;
        forever begin
            #half_period_ns clock = ~clock;
        end
    end

endmodule

`default_nettype wire
